/* verilog/rename_pkg.sv */
// Shared sizes and packed structs for the rename core; import it into each RTL and bench module
package rename_pkg;

    // Architectural register file and reorder buffer sizes
    localparam int DATA_WIDTH     = 32;
    localparam int NUM_REGS       = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int ROB_DEPTH      = 8;
    localparam int TAG_WIDTH      = 3;

    // Clock cycles a testbench wait allows before it gives up
    localparam int WAIT_LIMIT     = 64;

    // One instruction as it enters dispatch
    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] rdest;
        logic [REG_ADDR_WIDTH-1:0] rsrc0;
        logic [REG_ADDR_WIDTH-1:0] rsrc1;
    } disp_req_t;

    // A source operand, either a committed value or the tag of its producer
    typedef struct packed {
        logic                  rdy;
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] data;
    } operand_t;

    // Renamed instruction handed on to issue
    typedef struct packed {
        logic [TAG_WIDTH-1:0]      tag;
        logic [REG_ADDR_WIDTH-1:0] rdest;
        operand_t                  op0;
        operand_t                  op1;
    } issue_t;

    // Execution result, addressed to a reorder slot
    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] data;
    } cmpl_t;

    // Retired instruction as reported to the outside
    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] rdest;
        logic [TAG_WIDTH-1:0]      tag;
        logic [DATA_WIDTH-1:0]     data;
    } commit_t;

    // Visible state of one reorder slot
    typedef struct packed {
        logic                      busy;
        logic                      done;
        logic [REG_ADDR_WIDTH-1:0] rdest;
        logic [DATA_WIDTH-1:0]     data;
    } rob_slot_t;

    // Register map write, used for both the tag write and the value write
    typedef struct packed {
        logic                      en;
        logic [REG_ADDR_WIDTH-1:0] rdest;
        logic [TAG_WIDTH-1:0]      tag;
        logic [DATA_WIDTH-1:0]     data;
    } map_wr_t;

endpackage

/* verilog/register_map.sv */
// Register map holding committed value, producer tag and ready bit per register, with two lookups
module register_map
    import rename_pkg::*;
(
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      flush,
    input  logic [REG_ADDR_WIDTH-1:0] rsrc0,
    input  logic [REG_ADDR_WIDTH-1:0] rsrc1,
    output operand_t                  op0,
    output operand_t                  op1,
    input  map_wr_t                   tag_wr,
    input  map_wr_t                   val_wr
);

    // Committed value, producer tag and ready bit of every register
    logic [DATA_WIDTH-1:0] data_q [NUM_REGS];
    logic [TAG_WIDTH-1:0]  tag_q  [NUM_REGS];
    logic [NUM_REGS-1:0]   rdy_q;

    logic tag_en;
    logic val_en;
    logic val_match;

    // r0 is hardwired, so writes aimed at it are dropped here
    assign tag_en = tag_wr.en && (tag_wr.rdest != '0);
    assign val_en = val_wr.en && (val_wr.rdest != '0);

    // Only the newest producer of a register may mark it ready again
    assign val_match = val_en && (tag_q[val_wr.rdest] == val_wr.tag);

    // Combinational lookup of one source against the state before this edge
    function automatic operand_t lookup(input logic [REG_ADDR_WIDTH-1:0] rs);
        operand_t op;
        op.rdy  = rdy_q[rs];
        op.tag  = tag_q[rs];
        op.data = data_q[rs];
        // Bypass the value that retires in this very cycle
        if (val_en && (val_wr.rdest == rs) && (tag_q[rs] == val_wr.tag)) begin
            op.rdy  = 1'b1;
            op.data = val_wr.data;
        end
        // r0 reads as zero and is always ready
        if (rs == '0) begin
            op.rdy  = 1'b1;
            op.tag  = '0;
            op.data = '0;
        end
        return op;
    endfunction

    always_comb begin
        op0 = lookup(rsrc0);
        op1 = lookup(rsrc1);
    end

    // Dispatch records which slot will produce the register
    always_ff @(posedge clk) begin
        if (tag_en) begin
            tag_q[tag_wr.rdest] <= tag_wr.tag;
        end
    end

    // Retire always stores the value, even from an older producer
    always_ff @(posedge clk) begin
        if (val_en) begin
            data_q[val_wr.rdest] <= val_wr.data;
        end
    end

    // Flush brings back the committed values by setting every ready bit
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rdy_q <= '1;
        end else if (flush) begin
            rdy_q <= '1;
        end else begin
            if (val_match) begin
                rdy_q[val_wr.rdest] <= 1'b1;
            end
            // The later assignment wins, so a new producer keeps the register busy
            if (tag_en) begin
                rdy_q[tag_wr.rdest] <= 1'b0;
            end
        end
    end

endmodule

/* verilog/rob_slot.sv */
// One reorder buffer slot with its destination, result and busy and done flags
module rob_slot
    import rename_pkg::*;
#(
    parameter logic [TAG_WIDTH-1:0] SLOT_ID = '0
) (
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      flush,
    input  logic                      alloc,
    input  logic [REG_ADDR_WIDTH-1:0] alloc_rdest,
    input  logic                      cmpl_valid,
    input  cmpl_t                     cmpl,
    input  logic                      free,
    output rob_slot_t                 state
);

    logic                      busy_q;
    logic                      done_q;
    logic [REG_ADDR_WIDTH-1:0] rdest_q;
    logic [DATA_WIDTH-1:0]     data_q;
    logic                      hit;

    // A completion counts only for this slot while it waits for its result
    assign hit = cmpl_valid && (cmpl.tag == SLOT_ID) && busy_q && !done_q;

    // Control flags
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (flush || free) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (alloc) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
        end else if (hit) begin
            done_q <= 1'b1;
        end
    end

    // Destination and result of the instruction held in this slot
    always_ff @(posedge clk) begin
        if (alloc) begin
            rdest_q <= alloc_rdest;
        end
        if (hit) begin
            data_q <= cmpl.data;
        end
    end

    assign state = '{busy: busy_q, done: done_q, rdest: rdest_q, data: data_q};

endmodule

/* verilog/rob_dispatch.sv */
// Dispatch stage that renames sources, allocates the tail slot and registers the issue result
module rob_dispatch
    import rename_pkg::*;
(
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      flush,
    input  logic                      disp_valid,
    input  disp_req_t                 disp_req,
    output logic                      disp_ready,
    input  logic                      tail_busy,
    output logic [REG_ADDR_WIDTH-1:0] rsrc0,
    output logic [REG_ADDR_WIDTH-1:0] rsrc1,
    input  operand_t                  op0,
    input  operand_t                  op1,
    output map_wr_t                   tag_wr,
    output logic [ROB_DEPTH-1:0]      alloc,
    output logic [REG_ADDR_WIDTH-1:0] alloc_rdest,
    output logic                      issue_valid,
    output issue_t                    issue
);

    logic [TAG_WIDTH-1:0] tail_q;
    logic                 accept;
    logic                 issue_valid_q;
    issue_t               issue_q;

    // A busy tail slot means all slots are in use
    // Nothing is taken during a flush, because that edge empties the buffer
    assign disp_ready = !tail_busy && !flush;
    assign accept     = disp_valid && disp_ready;

    // Sources go straight to the register map
    assign rsrc0 = disp_req.rsrc0;
    assign rsrc1 = disp_req.rsrc1;

    // The tag field always carries the tail, which the top level uses to pick the tail slot
    assign tag_wr = '{en: accept, rdest: disp_req.rdest, tag: tail_q, data: '0};

    assign alloc       = accept ? (ROB_DEPTH'(1) << tail_q) : '0;
    assign alloc_rdest = disp_req.rdest;

    // Tail pointer wraps naturally over the eight slots
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            tail_q        <= '0;
            issue_valid_q <= 1'b0;
        end else if (flush) begin
            tail_q        <= '0;
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= accept;
            if (accept) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    // Operands are captured as they looked up in the acceptance cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_q <= '{tag: tail_q, rdest: disp_req.rdest, op0: op0, op1: op1};
        end
    end

    assign issue_valid = issue_valid_q;
    assign issue       = issue_q;

endmodule

/* verilog/rob_retire.sv */
// Retire stage that commits the head slot in order into the register map and the commit port
module rob_retire
    import rename_pkg::*;
(
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 flush,
    input  rob_slot_t            head_state,
    output logic [TAG_WIDTH-1:0] head,
    output logic [ROB_DEPTH-1:0] free,
    output map_wr_t              val_wr,
    output logic                 commit_valid,
    output commit_t              commit,
    input  logic                 commit_ready
);

    logic [TAG_WIDTH-1:0] head_q;
    logic                 take;

    // The oldest slot is offered once its result has arrived
    assign commit_valid = head_state.busy && head_state.done;
    assign take         = commit_valid && commit_ready;

    assign commit = '{rdest: head_state.rdest, tag: head_q, data: head_state.data};

    // A taken commit releases the slot for dispatch on the same edge
    assign free = take ? (ROB_DEPTH'(1) << head_q) : '0;

    // The map checks the tag to tell whether this is still the newest producer
    assign val_wr = '{
        en:    take,
        rdest: head_state.rdest,
        tag:   head_q,
        data:  head_state.data
    };

    // Head pointer, in step with the tail after a flush
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            head_q <= '0;
        end else if (flush) begin
            head_q <= '0;
        end else if (take) begin
            head_q <= head_q + 1'b1;
        end
    end

    assign head = head_q;

endmodule

/* verilog/rename_top.sv */
// Top level of the rename core joining dispatch, the reorder slots, retire and the register map
module rename_top
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,
    input  logic      flush,
    input  logic      disp_valid,
    input  disp_req_t disp_req,
    output logic      disp_ready,
    output logic      issue_valid,
    output issue_t    issue,
    input  logic      cmpl_valid,
    input  cmpl_t     cmpl,
    output logic      commit_valid,
    output commit_t   commit,
    input  logic      commit_ready
);

    logic [REG_ADDR_WIDTH-1:0] rsrc0;
    logic [REG_ADDR_WIDTH-1:0] rsrc1;
    operand_t                  op0;
    operand_t                  op1;
    map_wr_t                   tag_wr;
    map_wr_t                   val_wr;
    logic [ROB_DEPTH-1:0]      alloc;
    logic [REG_ADDR_WIDTH-1:0] alloc_rdest;
    logic [ROB_DEPTH-1:0]      free;
    logic [TAG_WIDTH-1:0]      head;
    rob_slot_t                 slot_state [ROB_DEPTH];

    rob_dispatch u_dispatch (
        .clk, .n_rst, .flush,
        .disp_valid, .disp_req, .disp_ready,
        // The tag field of the tag write always holds the tail index
        .tail_busy   (slot_state[tag_wr.tag].busy),
        .rsrc0, .rsrc1, .op0, .op1,
        .tag_wr, .alloc, .alloc_rdest,
        .issue_valid, .issue
    );

    // Each slot watches the completion bus for its own index
    for (genvar i = 0; i < ROB_DEPTH; i++) begin : g_slot
        rob_slot #(.SLOT_ID(TAG_WIDTH'(i))) u_slot (
            .clk, .n_rst, .flush,
            .alloc       (alloc[i]),
            .alloc_rdest,
            .cmpl_valid, .cmpl,
            .free        (free[i]),
            .state       (slot_state[i])
        );
    end

    rob_retire u_retire (
        .clk, .n_rst, .flush,
        .head_state  (slot_state[head]),
        .head, .free, .val_wr,
        .commit_valid, .commit, .commit_ready
    );

    register_map u_map (
        .clk, .n_rst, .flush,
        .rsrc0, .rsrc1, .op0, .op1,
        .tag_wr, .val_wr
    );

endmodule

/* bench/rename_assert.sv */
// Concurrent protocol checks for the rename core, attached to rename_top by a bind in the testbench
module rename_assert
    import rename_pkg::*;
(
    input logic    clk,
    input logic    n_rst,
    input logic    flush,
    input logic    disp_valid,
    input logic    disp_ready,
    input logic    issue_valid,
    input logic    commit_valid,
    input commit_t commit,
    input logic    commit_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // Number of assertion failures so far
    int fail_count = 0;

    // A stalled commit keeps its contents until retire takes it
    commit_stable: assert property (@(posedge clk) disable iff (!n_rst || flush)
        (commit_valid && !commit_ready) |=> $stable(commit))
        else begin
            $error("commit changed while commit_ready was low");
            fail_count++;
        end

    // Every accepted dispatch shows up on issue one cycle later
    issue_after_accept: assert property (@(posedge clk) disable iff (!n_rst)
        (disp_valid && disp_ready) |=> issue_valid)
        else begin
            $error("issue_valid missing one cycle after an accepted dispatch");
            fail_count++;
        end

    // And issue_valid never appears without an accepted dispatch before it
    issue_only_on_accept: assert property (@(posedge clk) disable iff (!n_rst)
        !(disp_valid && disp_ready) |=> !issue_valid)
        else begin
            $error("issue_valid high without an accepted dispatch");
            fail_count++;
        end

    // Flush empties every slot, so dispatch opens again once it drops
    ready_after_flush: assert property (@(posedge clk) disable iff (!n_rst)
        $fell(flush) |-> disp_ready)
        else begin
            $error("disp_ready low after a flush");
            fail_count++;
        end

    // Nothing is issued or committed straight out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $rose(n_rst) |-> (!issue_valid && !commit_valid))
        else begin
            $error("issue_valid or commit_valid high after reset");
            fail_count++;
        end

endmodule

/* bench/rename_tb.sv */
// Self-checking testbench for the rename core; run rename_tb as the top module over compile.f
module rename_tb
    import rename_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic      clk;
    logic      n_rst;
    logic      flush;
    logic      disp_valid;
    disp_req_t disp_req;
    logic      disp_ready;
    logic      issue_valid;
    issue_t    issue;
    logic      cmpl_valid;
    cmpl_t     cmpl;
    logic      commit_valid;
    commit_t   commit;
    logic      commit_ready;

    // Reference model of the register map and of the reorder slots
    logic [DATA_WIDTH-1:0]     m_val        [NUM_REGS];
    logic [TAG_WIDTH-1:0]      m_tag        [NUM_REGS];
    logic                      m_rdy        [NUM_REGS];
    logic                      m_known      [NUM_REGS];
    logic [REG_ADDR_WIDTH-1:0] m_slot_rdest [ROB_DEPTH];
    logic [DATA_WIDTH-1:0]     m_slot_data  [ROB_DEPTH];
    logic [TAG_WIDTH-1:0]      m_head;
    logic [TAG_WIDTH-1:0]      m_tail;

    logic [31:0] lfsr = 32'hec19_bd98;
    string       cur_test;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_failed;

    rename_top dut (.*);

    bind rename_top rename_assert u_assert (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s %s expected %0h actual %0h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s: gave up waiting for %s", cur_test, what);
        test_errs++;
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once for every data bit
    function automatic logic [DATA_WIDTH-1:0] draw_word();
        logic [DATA_WIDTH-1:0] w;
        w = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            w    = {w[DATA_WIDTH-2:0], lfsr[0]};
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        end
        return w;
    endfunction

    // Registers that were never committed hold no known value, so only their ready bit counts
    task automatic check_operand(input string what, input logic [REG_ADDR_WIDTH-1:0] rs,
                                 input operand_t act);
        check_value({what, " rdy"}, 64'(m_rdy[rs]), 64'(act.rdy));
        if (m_rdy[rs] && m_known[rs]) begin
            check_value({what, " data"}, 64'(m_val[rs]), 64'(act.data));
        end else if (!m_rdy[rs]) begin
            check_value({what, " tag"}, 64'(m_tag[rs]), 64'(act.tag));
        end
    endtask

    task automatic reset_model();
        for (int r = 0; r < NUM_REGS; r++) begin
            m_val[r]   = '0;
            m_tag[r]   = '0;
            m_rdy[r]   = 1'b1;
            m_known[r] = (r == 0);
        end
        m_head = '0;
        m_tail = '0;
    endtask

    // Flush makes the committed values current again and restarts both pointers
    task automatic flush_model();
        for (int r = 0; r < NUM_REGS; r++) begin
            m_rdy[r] = 1'b1;
        end
        m_head = '0;
        m_tail = '0;
    endtask

    task automatic dispatch_instr(input logic [REG_ADDR_WIDTH-1:0] rd,
                                  input logic [REG_ADDR_WIDTH-1:0] rs0,
                                  input logic [REG_ADDR_WIDTH-1:0] rs1);
        int waited;
        waited = 0;
        while (!disp_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!disp_ready) begin
            report_timeout("disp_ready");
            return;
        end
        disp_valid = 1'b1;
        disp_req   = '{rdest: rd, rsrc0: rs0, rsrc1: rs1};
        @(negedge clk);
        disp_valid = 1'b0;
        // The model still holds the state of the acceptance cycle here
        check_value("issue_valid", 64'd1, 64'(issue_valid));
        check_value("issue tag", 64'(m_tail), 64'(issue.tag));
        check_value("issue rdest", 64'(rd), 64'(issue.rdest));
        check_operand("op0", rs0, issue.op0);
        check_operand("op1", rs1, issue.op1);
        if (rd != '0) begin
            m_tag[rd] = m_tail;
            m_rdy[rd] = 1'b0;
        end
        m_slot_rdest[m_tail] = rd;
        m_tail = TAG_WIDTH'(m_tail + 1);
    endtask

    task automatic complete_slot(input logic [TAG_WIDTH-1:0] tag);
        logic [DATA_WIDTH-1:0] d;
        d          = draw_word();
        cmpl_valid = 1'b1;
        cmpl       = '{tag: tag, data: d};
        m_slot_data[tag] = d;
        @(negedge clk);
        cmpl_valid = 1'b0;
    endtask

    // Waits for the head to be offered, holds it for a while, then takes it
    task automatic commit_head(input int hold);
        commit_t exp;
        int      waited;
        exp    = '{rdest: m_slot_rdest[m_head], tag: m_head, data: m_slot_data[m_head]};
        waited = 0;
        while (!commit_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!commit_valid) begin
            report_timeout("commit_valid");
            return;
        end
        for (int i = 0; i < hold; i++) begin
            check_value("held commit", 64'(exp), 64'(commit));
            @(negedge clk);
        end
        check_value("commit", 64'(exp), 64'(commit));
        commit_ready = 1'b1;
        @(negedge clk);
        commit_ready = 1'b0;
        // Only the newest producer makes its register ready again
        if (exp.rdest != '0) begin
            m_val[exp.rdest]   = exp.data;
            m_known[exp.rdest] = 1'b1;
            if (m_tag[exp.rdest] == exp.tag) begin
                m_rdy[exp.rdest] = 1'b1;
            end
        end
        m_head = TAG_WIDTH'(m_head + 1);
    endtask

    // One instruction all the way through, with nothing else in flight
    task automatic run_through(input logic [REG_ADDR_WIDTH-1:0] rd,
                               input logic [REG_ADDR_WIDTH-1:0] rs0,
                               input logic [REG_ADDR_WIDTH-1:0] rs1);
        dispatch_instr(rd, rs0, rs1);
        complete_slot(m_head);
        commit_head(0);
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: failed with %0d errors", cur_test, test_errs);
            tests_failed++;
        end
    endtask

    initial begin
        n_rst        = 1'b0;
        flush        = 1'b0;
        disp_valid   = 1'b0;
        disp_req     = '0;
        cmpl_valid   = 1'b0;
        cmpl         = '0;
        commit_ready = 1'b0;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_model();
        repeat (5) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        @(negedge clk);

        // A write to r0 retires normally but leaves r0 at zero
        begin_test("r0_not_renamed");
        run_through(5'd0, 5'd0, 5'd0);
        run_through(5'd1, 5'd0, 5'd0);
        finish_test();

        // The reader of r5 sees the writer's tag, later readers see its value
        begin_test("dependency");
        dispatch_instr(5'd5, 5'd0, 5'd0);
        dispatch_instr(5'd6, 5'd5, 5'd0);
        complete_slot(m_head);
        complete_slot(TAG_WIDTH'(m_head + 1));
        commit_head(0);
        commit_head(0);
        run_through(5'd7, 5'd5, 5'd6);
        finish_test();

        // Results arrive youngest first but retire oldest first
        begin_test("in_order_commit");
        dispatch_instr(5'd8, 5'd5, 5'd6);
        dispatch_instr(5'd9, 5'd8, 5'd0);
        dispatch_instr(5'd10, 5'd9, 5'd8);
        complete_slot(TAG_WIDTH'(m_head + 2));
        complete_slot(TAG_WIDTH'(m_head + 1));
        complete_slot(m_head);
        commit_head(3);
        commit_head(0);
        commit_head(0);
        finish_test();

        // Fill every slot, then free the head and watch the tail wrap onto it
        begin_test("back_pressure");
        for (int i = 0; i < ROB_DEPTH; i++) begin
            dispatch_instr(REG_ADDR_WIDTH'(11 + i), REG_ADDR_WIDTH'(i), 5'd0);
        end
        repeat (2) begin
            check_value("disp_ready when full", 64'd0, 64'(disp_ready));
            @(negedge clk);
        end
        complete_slot(m_head);
        commit_head(0);
        dispatch_instr(5'd19, 5'd11, 5'd12);
        for (int i = 0; i < ROB_DEPTH; i++) begin
            complete_slot(TAG_WIDTH'(m_head + i));
        end
        for (int i = 0; i < ROB_DEPTH; i++) begin
            commit_head(0);
        end
        finish_test();

        // The older writer of r20 retires, but r20 keeps waiting on the newer one
        begin_test("stale_commit");
        dispatch_instr(5'd20, 5'd0, 5'd0);
        dispatch_instr(5'd20, 5'd0, 5'd0);
        complete_slot(m_head);
        commit_head(0);
        dispatch_instr(5'd21, 5'd20, 5'd0);
        complete_slot(m_head);
        commit_head(0);
        dispatch_instr(5'd22, 5'd20, 5'd0);
        complete_slot(m_head);
        complete_slot(TAG_WIDTH'(m_head + 1));
        commit_head(0);
        commit_head(0);
        finish_test();

        // A finished head is dropped by the flush and never offered again
        begin_test("flush");
        dispatch_instr(5'd20, 5'd21, 5'd0);
        dispatch_instr(5'd21, 5'd20, 5'd0);
        complete_slot(m_head);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        flush_model();
        repeat (3) begin
            check_value("commit_valid after flush", 64'd0, 64'(commit_valid));
            @(negedge clk);
        end
        run_through(5'd25, 5'd20, 5'd21);
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, total_errs, dut.u_assert.fail_count);
        if (total_errs == 0 && dut.u_assert.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* compile.f */
verilog/rename_pkg.sv
verilog/register_map.sv
verilog/rob_slot.sv
verilog/rob_dispatch.sv
verilog/rob_retire.sv
verilog/rename_top.sv
bench/rename_assert.sv
bench/rename_tb.sv

/* Makefile */
TOP := rename_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f compile.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
